/* dv/multihTopTb.sv */
// Inputs change on the falling edge and outputs are sampled there; model assumes default DAC width
`timescale 1ns/1ps

module multihTopTb;

  localparam logic [15:0] VerNumber   = 16'ha53c;
  localparam int          TotalCycles = 5 + 5 + 40 + 16 + 60 + 80 + 80 + 30;
  localparam int          WatchdogNs  = TotalCycles * 100 * 2;

  // One cycle of pin stimulus
  typedef struct packed {
    logic [3:0]                 mode;
    logic [2:0][3:0]            sel;
    logic [2:0][13:0]           data;
    demodPkg::trellisTapT [2:0] tap;
    demodPkg::symbolT           trDec;
    demodPkg::symbolT           legSym;
    logic                       auClk;
    demodPkg::phaseErrT         phErr;
  } stimT;

  logic                 ck933;
  logic                 rs;
  demodPkg::cpuBusT     bus;
  stimT                 cur;
  stimT                 hist[$];   // Newest entry last
  logic [15:0]          dataRd;
  logic                 readEn;
  logic [13:0]          dac0;
  logic [13:0]          dac1;
  logic [13:0]          dac2;
  logic                 dacRst;
  demodPkg::phaseErrT   phaseErr;
  logic                 doutI;
  logic                 doutQ;
  logic                 coutI;
  logic                 coutQ;
  logic                 symEn;
  logic                 sym2xEn;

  // Model state
  logic [2:0][13:0]     dacModel;
  demodPkg::symbolT     expDec;
  logic                 expDoutQ;
  logic                 expCoutQ;
  demodPkg::phaseErrT   expPhErr;
  logic                 rstExpected;
  int                   errorCount;
  int                   testErrors;
  int                   checkCount;
  int                   testCount;

  multihTop #(.VER_NUMBER(VerNumber), .RESET_STRETCH(5)) i_dut (
    .ck933(ck933), .rs(rs), .bus_i(bus), .dataRd_o(dataRd), .readEn_o(readEn),
    .dac0Select_i(cur.sel[0]), .dac1Select_i(cur.sel[1]), .dac2Select_i(cur.sel[2]),
    .dac0Data_i(cur.data[0]), .dac1Data_i(cur.data[1]), .dac2Data_i(cur.data[2]),
    .trellisTap0_i(cur.tap[0]), .trellisTap1_i(cur.tap[1]), .trellisTap2_i(cur.tap[2]),
    .dac0_o(dac0), .dac1_o(dac1), .dac2_o(dac2), .dacRst_o(dacRst),
    .demodMode_i(cur.mode), .trellisDec_i(cur.trDec), .legacySym_i(cur.legSym),
    .auSymClk_i(cur.auClk), .phaseErr_i(cur.phErr), .phaseErr_o(phaseErr),
    .doutI_o(doutI), .doutQ_o(doutQ), .coutI_o(coutI), .coutQ_o(coutQ),
    .symEn_o(symEn), .sym2xEn_o(sym2xEn)
  );

  initial begin
    ck933 = 1'b0;
    forever #50 ck933 = ~ck933;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before all tests completed");
    $display("Finished with errors");
    $finish;
  end

  // **************************************************
  // Checking helpers
  // **************************************************
  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      testErrors++;
      $display("FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Expected outputs from the pin latencies of DAC 3, trellis 2, legacy 3 and override 1
  task automatic updateModel();
    stimT s1;
    stimT s2;
    stimT s3;
    logic trellis;
    s1 = hist[hist.size()-1];
    s2 = hist[hist.size()-2];
    s3 = hist[hist.size()-3];
    for (int ch = 0; ch < 3; ch++) begin
      trellis = (s3.mode == demodPkg::ModeMultih) &&
                (s3.sel[ch] == demodPkg::DacTrellisI ||
                 s3.sel[ch] == demodPkg::DacTrellisQ ||
                 s3.sel[ch] == demodPkg::DacTrellisPherr ||
                 s3.sel[ch] == demodPkg::DacTrellisIndex);
      if (!trellis) begin
        dacModel[ch] = {~s3.data[ch][13], s3.data[ch][12:0]};
      end else if (s3.tap[ch].sync) begin
        dacModel[ch] = {~s3.tap[ch].data[17], s3.tap[ch].data[16:4]};
      end
    end
    expDec   = (s2.mode == demodPkg::ModeMultih) ? s2.trDec : s3.legSym;
    expDoutQ = (s1.mode == demodPkg::ModeAuqpsk) ? s1.legSym.q : expDec.q;
    expCoutQ = (s1.mode == demodPkg::ModeAuqpsk) ? s1.auClk : expDec.symEn;
    expPhErr = s2.phErr;
  endtask

  task automatic checkPipes();
    compareValue("dac0_o", dacModel[0], dac0);
    compareValue("dac1_o", dacModel[1], dac1);
    compareValue("dac2_o", dacModel[2], dac2);
    compareValue("doutI_o", expDec.i, doutI);
    compareValue("doutQ_o", expDoutQ, doutQ);
    compareValue("coutI_o", expDec.symEn, coutI);
    compareValue("coutQ_o", expCoutQ, coutQ);
    compareValue("symEn_o", expDec.symEn, symEn);
    compareValue("sym2xEn_o", expDec.sym2xEn, sym2xEn);
  endtask

  // selKind 0 any select, 1 never a trellis source, 2 mostly trellis codes
  task automatic randomizeInputs(input logic [3:0] mode, input int selKind);
    logic [3:0] s;
    cur.mode = mode;
    for (int ch = 0; ch < 3; ch++) begin
      cur.data[ch]     = 14'($urandom);
      cur.tap[ch].data = 18'($urandom);
      cur.tap[ch].sync = 1'($urandom);
      s = 4'($urandom);
      if (selKind == 1 && mode == demodPkg::ModeMultih && s[3:2] == 2'b10) begin
        s = s ^ 4'h4;   // Move into 0xc..0xf
      end else if (selKind == 2 && $urandom_range(3) != 0) begin
        s = 4'h8 + 4'($urandom_range(3));
      end
      cur.sel[ch] = s;
    end
    cur.trDec  = 4'($urandom);
    cur.legSym = 4'($urandom);
    cur.auClk  = 1'($urandom);
    cur.phErr  = 10'($urandom);
  endtask

  // Check at the falling edge, then drive the next inputs
  task automatic runCycle(input logic [3:0] mode, input int selKind, input bit pipeCheck);
    @(negedge ck933);
    if (hist.size() >= 3) begin
      updateModel();
      if (pipeCheck) begin
        checkPipes();
      end
      compareValue("phaseErr_o", expPhErr, phaseErr);
    end
    compareValue("dacRst_o", rstExpected, dacRst);
    if (rstExpected) begin
      compareValue("dac0_o", 0, dac0);   // Cleared by the core reset
      compareValue("dac1_o", 0, dac1);
      compareValue("dac2_o", 0, dac2);
    end
    randomizeInputs(mode, selKind);
    hist.push_back(cur);
    if (hist.size() > 4) begin
      hist.delete(0);
    end
  endtask

  task automatic finishTest(input string name);
    testCount++;
    $display("Test %s done with %0d errors", name, testErrors);
    testErrors = 0;
  endtask

  // **************************************************
  // Test sequence
  // **************************************************
  initial begin
    logic [15:0] expData;
    void'($urandom(32'h1de9b589));
    rs          = 1'b1;
    cur         = '0;
    bus         = '{csN: 1'b1, rdN: 1'b1, wrN: 1'b1, addr: '0};
    dacModel    = '0;
    rstExpected = 1'b0;
    errorCount  = 0;
    testErrors  = 0;
    checkCount  = 0;
    testCount   = 0;
    repeat (5) @(negedge ck933);
    rs = 1'b0;
    repeat (5) runCycle(4'h0, 1, 1'b0);   // Fill the pipelines
    testErrors = 0;

    for (int n = 0; n < 40; n++) begin
      runCycle(4'($urandom), 0, 1'b1);
      case ($urandom_range(3))
        0: bus.addr = {demodPkg::MiscVersion[11:2], 2'($urandom)};
        1: bus.addr = {8'h0f, 4'($urandom)};
        2: bus.addr = 12'($urandom);
        default: bus.addr = demodPkg::MiscVersion | 12'h002;
      endcase
      bus.csN = 1'($urandom);
      bus.rdN = 1'($urandom);
      bus.wrN = 1'b1;
      #1;
      expData = (bus.addr[11:2] == demodPkg::MiscVersion[11:2] && bus.addr[1]) ? VerNumber : '0;
      compareValue("dataRd_o", expData, dataRd);
      compareValue("readEn_o", !bus.csN && !bus.rdN, readEn);
    end
    bus = '{csN: 1'b1, rdN: 1'b1, wrN: 1'b1, addr: '0};
    finishTest("versionRead");

    runCycle(4'($urandom), 1, 1'b1);
    bus = '{csN: 1'b0, rdN: 1'b1, wrN: 1'b0, addr: demodPkg::MiscReset};
    for (int k = 1; k <= 15; k++) begin
      rstExpected = (k >= 3 && k <= 8);   // Six cycles starting two edges after the write
      runCycle(4'($urandom), 1, 1'b0);
      bus = '{csN: 1'b1, rdN: 1'b1, wrN: 1'b1, addr: '0};
    end
    rstExpected = 1'b0;
    finishTest("softReset");

    repeat (60) runCycle(4'($urandom), 1, 1'b1);
    finishTest("dacPassThrough");

    repeat (80) runCycle(demodPkg::ModeMultih, 2, 1'b1);
    finishTest("dacTrellisTap");

    for (int n = 0; n < 80; n++) begin
      case (n / 20)
        0: runCycle(demodPkg::ModeMultih, 0, 1'b1);
        1: runCycle(demodPkg::ModeAuqpsk, 0, 1'b1);
        2: runCycle(4'h0, 0, 1'b1);
        default: runCycle(4'($urandom), 0, 1'b1);
      endcase
    end
    finishTest("decisionSelect");

    repeat (30) runCycle(4'($urandom), 0, 1'b1);
    finishTest("phaseErrFeedback");

    $display("Ran %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/demodPkg.sv
rtl/padRegisters.sv
rtl/cpuRegisters.sv
rtl/resetStretcher.sv
rtl/dacOutputMux.sv
rtl/decisionSelect.sv
rtl/multihTop.sv
dv/multihTopTb.sv

/* rtl/cpuRegisters.sv */
// Misc space only; read data is combinational from addr and the soft reset is the only write
`timescale 1ns/1ps

module cpuRegisters #(
  parameter logic [demodPkg::DataWidth-1:0] VER_NUMBER = 16'h0124
) (
  input  logic                           ck933,
  input  logic                           rs,
  input  demodPkg::cpuBusT               bus_i,
  output logic [demodPkg::DataWidth-1:0] dataRd_o,
  output logic                           readEn_o,
  output logic                           softReset_o
);

  localparam int Dw = demodPkg::DataWidth;
  localparam int Aw = demodPkg::AddrWidth;

  logic            miscSpace;
  logic            versionHit;
  logic            resetWrite;
  logic [2*Dw-1:0] miscWord;   // Two halves picked by addr bit 1

  // **************************************************
  // Address decode
  // **************************************************
  assign miscSpace  = (bus_i.addr[Aw-1:demodPkg::MiscSpaceLsb] == demodPkg::MiscSpace);
  // Word decode where bit 1 only selects the half
  assign versionHit = (bus_i.addr[Aw-1:2] == demodPkg::MiscVersion[Aw-1:2]);

  assign miscWord = versionHit ? {VER_NUMBER, {Dw{1'b0}}} : '0;

  // **************************************************
  // Read data
  // **************************************************
  always_comb begin
    if (!miscSpace) begin
      dataRd_o = '0;   // Nothing else mapped
    end else if (bus_i.addr[1]) begin
      dataRd_o = miscWord[2*Dw-1:Dw];
    end else begin
      dataRd_o = miscWord[Dw-1:0];
    end
  end

  assign readEn_o = !bus_i.csN && !bus_i.rdN;

  // **************************************************
  // Soft reset write
  // **************************************************
  assign resetWrite = !bus_i.csN && !bus_i.wrN && (bus_i.addr == demodPkg::MiscReset);

  // One cycle strobe per sampled write
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      softReset_o <= 1'b0;
    end else begin
      softReset_o <= resetWrite;
    end
  end

endmodule

/* rtl/dacOutputMux.sv */
// One DAC channel; trellis taps used only in multih mode, DAC_WIDTH must not exceed the tap width
`timescale 1ns/1ps

module dacOutputMux #(
  parameter int DAC_WIDTH = demodPkg::DacWidth
) (
  input  logic                 ck933,
  input  logic                 rs,
  input  logic [3:0]           select_i,
  input  demodPkg::modeFlagsT  mode_i,
  input  logic [DAC_WIDTH-1:0] passData_i,
  input  demodPkg::trellisTapT tap_i,
  output logic [DAC_WIDTH-1:0] dac_o
);

  logic [3:0]           selectR;    // Lines up with the pad-registered data
  logic                 trellisSel;
  logic [DAC_WIDTH-1:0] stageVal;
  logic                 stageSync;

  always_comb begin
    case (selectR)
      demodPkg::DacTrellisI,
      demodPkg::DacTrellisQ,
      demodPkg::DacTrellisPherr,
      demodPkg::DacTrellisIndex: trellisSel = mode_i.multih;
      default:                   trellisSel = 1'b0;
    endcase
  end

  // **************************************************
  // Source select and sync-gated load
  // **************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      selectR   <= '0;
      stageVal  <= '0;
      stageSync <= 1'b0;
      dac_o     <= '0;
    end else begin
      selectR <= select_i;
      if (trellisSel) begin
        stageVal  <= tap_i.data[demodPkg::TapWidth-1 -: DAC_WIDTH];   // Top bits of the tap
        stageSync <= tap_i.sync;
      end else begin
        stageVal  <= passData_i;
        stageSync <= 1'b1;   // Pass-through loads every cycle
      end
      if (stageSync) begin
        // Offset binary for the converter
        dac_o <= {~stageVal[DAC_WIDTH-1], stageVal[DAC_WIDTH-2:0]};
      end
    end
  end

endmodule

/* rtl/decisionSelect.sv */
// Inputs are pad-registered; legacy path gets one extra stage, AUQPSK Q override is combinational
`timescale 1ns/1ps

module decisionSelect (
  input  logic                ck933,
  input  logic                rs,
  input  demodPkg::modeFlagsT mode_i,
  input  demodPkg::symbolT    trellisDec_i,
  input  demodPkg::symbolT    legacySym_i,
  input  logic                auSymClk_i,
  input  logic                qDataRaw_i,
  output logic                doutI_o,
  output logic                doutQ_o,
  output logic                coutI_o,
  output logic                coutQ_o,
  output logic                symEn_o,
  output logic                sym2xEn_o
);

  demodPkg::symbolT legacyDly;   // Extra legacy stage
  demodPkg::symbolT decOut;

  // **************************************************
  // Source select
  // **************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      legacyDly <= '0;
      decOut    <= '0;
    end else begin
      legacyDly <= legacySym_i;
      if (mode_i.multih) begin
        decOut <= trellisDec_i;
      end else begin
        decOut <= legacyDly;
      end
    end
  end

  assign doutI_o   = decOut.i;
  assign coutI_o   = decOut.symEn;   // Symbol clock to the I pin
  assign symEn_o   = decOut.symEn;
  assign sym2xEn_o = decOut.sym2xEn;

  // AUQPSK carries raw Q on its own clock
  assign doutQ_o = mode_i.auqpsk ? qDataRaw_i : decOut.q;
  assign coutQ_o = mode_i.auqpsk ? auSymClk_i : decOut.symEn;

endmodule

/* rtl/demodPkg.sv */
// Shared codes and bus layouts; mode, DAC-select and address values must match the processor map
package demodPkg;

  // **************************************************
  // Widths
  // **************************************************
  localparam int AddrWidth  = 12;   // Processor byte address
  localparam int DataWidth  = 16;   // Processor data bus
  localparam int TapWidth   = 18;   // Trellis tap word
  localparam int DacWidth   = 14;   // Converter resolution
  localparam int PhErrWidth = 8;

  // **************************************************
  // Codes
  // **************************************************
  // Demod mode
  localparam logic [3:0] ModeAuqpsk = 4'h5;
  localparam logic [3:0] ModeMultih = 4'h7;

  // DAC source selects that pick a trellis tap
  localparam logic [3:0] DacTrellisI     = 4'h8;
  localparam logic [3:0] DacTrellisQ     = 4'h9;
  localparam logic [3:0] DacTrellisPherr = 4'ha;
  localparam logic [3:0] DacTrellisIndex = 4'hb;

  // Misc space is marked by the upper eight address bits
  localparam int               MiscSpaceLsb = 4;
  localparam logic [7:0]       MiscSpace    = 8'h0f;
  localparam logic [AddrWidth-1:0] MiscReset   = 12'h0f0;   // Write only
  localparam logic [AddrWidth-1:0] MiscVersion = 12'h0f4;   // Bit 1 picks the half

  // **************************************************
  // Bundles
  // **************************************************
  typedef struct packed {
    logic                 csN;
    logic                 rdN;
    logic                 wrN;
    logic [AddrWidth-1:0] addr;
  } cpuBusT;

  // One trellis tap and the strobe that qualifies it
  typedef struct packed {
    logic [TapWidth-1:0] data;
    logic                sync;
  } trellisTapT;

  typedef struct packed {
    logic i;
    logic q;
    logic symEn;     // Symbol rate enable
    logic sym2xEn;   // Twice symbol rate
  } symbolT;

  typedef struct packed {
    logic [PhErrWidth-1:0] value;
    logic                  en;
    logic                  valid;
  } phaseErrT;

  // Mode decoded once at the pads
  typedef struct packed {
    logic multih;
    logic auqpsk;
  } modeFlagsT;

endpackage

/* rtl/multihTop.sv */
// Glue around external trellis cores; DAC_WIDTH must equal the package DAC width, no tristate bus
`timescale 1ns/1ps

module multihTop #(
  parameter logic [demodPkg::DataWidth-1:0] VER_NUMBER    = 16'h0124,
  parameter int                             RESET_STRETCH = 5,
  parameter int                             DAC_WIDTH     = demodPkg::DacWidth
) (
  input  logic                           ck933,
  input  logic                           rs,
  // Processor bus
  input  demodPkg::cpuBusT               bus_i,
  output logic [demodPkg::DataWidth-1:0] dataRd_o,
  output logic                           readEn_o,
  // DAC channels
  input  logic [3:0]                     dac0Select_i,
  input  logic [3:0]                     dac1Select_i,
  input  logic [3:0]                     dac2Select_i,
  input  logic [demodPkg::DacWidth-1:0]  dac0Data_i,
  input  logic [demodPkg::DacWidth-1:0]  dac1Data_i,
  input  logic [demodPkg::DacWidth-1:0]  dac2Data_i,
  input  demodPkg::trellisTapT           trellisTap0_i,
  input  demodPkg::trellisTapT           trellisTap1_i,
  input  demodPkg::trellisTapT           trellisTap2_i,
  output logic [DAC_WIDTH-1:0]           dac0_o,
  output logic [DAC_WIDTH-1:0]           dac1_o,
  output logic [DAC_WIDTH-1:0]           dac2_o,
  output logic                           dacRst_o,
  // Mode, decisions and feedback
  input  logic [3:0]                     demodMode_i,
  input  demodPkg::symbolT               trellisDec_i,
  input  demodPkg::symbolT               legacySym_i,
  input  logic                           auSymClk_i,
  input  demodPkg::phaseErrT             phaseErr_i,
  output demodPkg::phaseErrT             phaseErr_o,
  output logic                           doutI_o,
  output logic                           doutQ_o,
  output logic                           coutI_o,
  output logic                           coutQ_o,
  output logic                           symEn_o,
  output logic                           sym2xEn_o
);

  logic [2:0][demodPkg::DacWidth-1:0] dacDataR;
  demodPkg::trellisTapT [2:0]         trellisTapR;
  demodPkg::symbolT                   trellisDecR;
  demodPkg::symbolT                   legacySymR;
  demodPkg::modeFlagsT                modeFlags;
  logic                               auSymClkR;
  logic                               qDataRaw;
  logic                               softReset;
  logic                               coreReset;

  // **************************************************
  // Pads and processor space
  // **************************************************
  padRegisters u_pads (
    .ck933(ck933), .rs(rs), .demodMode_i(demodMode_i),
    .dacData_i({dac2Data_i, dac1Data_i, dac0Data_i}),
    .trellisTap_i({trellisTap2_i, trellisTap1_i, trellisTap0_i}),
    .trellisDec_i(trellisDec_i), .legacySym_i(legacySym_i), .auSymClk_i(auSymClk_i),
    .phaseErr_i(phaseErr_i), .dacData_o(dacDataR), .trellisTap_o(trellisTapR),
    .trellisDec_o(trellisDecR), .legacySym_o(legacySymR), .auSymClk_o(auSymClkR),
    .qDataRaw_o(qDataRaw), .mode_o(modeFlags), .phaseErr_o(phaseErr_o)
  );

  cpuRegisters #(.VER_NUMBER(VER_NUMBER)) u_cpuRegs (
    .ck933(ck933), .rs(rs), .bus_i(bus_i),
    .dataRd_o(dataRd_o), .readEn_o(readEn_o), .softReset_o(softReset)
  );

  resetStretcher #(.RESET_STRETCH(RESET_STRETCH)) u_resetStretch (
    .ck933(ck933), .rs(rs), .softReset_i(softReset), .coreReset_o(coreReset)
  );

  assign dacRst_o = coreReset;   // Converter reset pin

  // **************************************************
  // Output pipelines, cleared by either reset
  // **************************************************
  dacOutputMux #(.DAC_WIDTH(DAC_WIDTH)) u_dac0 (
    .ck933(ck933), .rs(rs | coreReset), .select_i(dac0Select_i), .mode_i(modeFlags),
    .passData_i(dacDataR[0]), .tap_i(trellisTapR[0]), .dac_o(dac0_o)
  );

  dacOutputMux #(.DAC_WIDTH(DAC_WIDTH)) u_dac1 (
    .ck933(ck933), .rs(rs | coreReset), .select_i(dac1Select_i), .mode_i(modeFlags),
    .passData_i(dacDataR[1]), .tap_i(trellisTapR[1]), .dac_o(dac1_o)
  );

  dacOutputMux #(.DAC_WIDTH(DAC_WIDTH)) u_dac2 (
    .ck933(ck933), .rs(rs | coreReset), .select_i(dac2Select_i), .mode_i(modeFlags),
    .passData_i(dacDataR[2]), .tap_i(trellisTapR[2]), .dac_o(dac2_o)
  );

  decisionSelect u_decSel (
    .ck933(ck933), .rs(rs | coreReset), .mode_i(modeFlags),
    .trellisDec_i(trellisDecR), .legacySym_i(legacySymR),
    .auSymClk_i(auSymClkR), .qDataRaw_i(qDataRaw),
    .doutI_o(doutI_o), .doutQ_o(doutQ_o), .coutI_o(coutI_o), .coutQ_o(coutQ_o),
    .symEn_o(symEn_o), .sym2xEn_o(sym2xEn_o)
  );

endmodule

/* rtl/padRegisters.sv */
// All inputs reclocked once on ck933; only demodMode decoder; phase error takes two cycles pin to pin
`timescale 1ns/1ps

module padRegisters (
  input  logic                                       ck933,
  input  logic                                       rs,
  input  logic [3:0]                                 demodMode_i,
  input  logic [2:0][demodPkg::DacWidth-1:0]         dacData_i,
  input  demodPkg::trellisTapT [2:0]                 trellisTap_i,
  input  demodPkg::symbolT                           trellisDec_i,
  input  demodPkg::symbolT                           legacySym_i,
  input  logic                                       auSymClk_i,
  input  demodPkg::phaseErrT                         phaseErr_i,
  output logic [2:0][demodPkg::DacWidth-1:0]         dacData_o,
  output demodPkg::trellisTapT [2:0]                 trellisTap_o,
  output demodPkg::symbolT                           trellisDec_o,
  output demodPkg::symbolT                           legacySym_o,
  output logic                                       auSymClk_o,
  output logic                                       qDataRaw_o,
  output demodPkg::modeFlagsT                        mode_o,
  output demodPkg::phaseErrT                         phaseErr_o
);

  demodPkg::phaseErrT phaseErrIn;   // First stage of the feedback

  // **************************************************
  // Input reclock
  // **************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      dacData_o    <= '0;
      trellisTap_o <= '0;
      trellisDec_o <= '0;
      legacySym_o  <= '0;
      auSymClk_o   <= 1'b0;
      mode_o       <= '0;
    end else begin
      dacData_o    <= dacData_i;
      trellisTap_o <= trellisTap_i;
      trellisDec_o <= trellisDec_i;
      legacySym_o  <= legacySym_i;
      auSymClk_o   <= auSymClk_i;
      mode_o.multih <= (demodMode_i == demodPkg::ModeMultih);
      mode_o.auqpsk <= (demodMode_i == demodPkg::ModeAuqpsk);
    end
  end

  // Raw Q for the AUQPSK override
  assign qDataRaw_o = legacySym_o.q;

  // **************************************************
  // Phase error feedback
  // **************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      phaseErrIn <= '0;
      phaseErr_o <= '0;
    end else begin
      phaseErrIn <= phaseErr_i;   // Pad in
      phaseErr_o <= phaseErrIn;   // Pad out
    end
  end

endmodule

/* rtl/resetStretcher.sv */
// Core reset rises two edges after the strobe and lasts RESET_STRETCH+1 cycles; RESET_STRETCH 1 to 8
`timescale 1ns/1ps

module resetStretcher #(
  parameter int RESET_STRETCH = 5
) (
  input  logic ck933,
  input  logic rs,
  input  logic softReset_i,
  output logic coreReset_o
);

  logic       sync0;
  logic       sync1;
  logic [2:0] stretchCnt;   // Down-counter after the sync chain

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      sync0       <= 1'b0;
      sync1       <= 1'b0;
      stretchCnt  <= '0;
      coreReset_o <= 1'b0;
    end else begin
      sync0 <= softReset_i;
      sync1 <= sync0;
      if (sync1) begin
        stretchCnt <= 3'(RESET_STRETCH - 1);   // A new request restarts the count
      end else if (stretchCnt != 0) begin
        stretchCnt <= stretchCnt - 3'd1;
      end
      // Held from the first sync stage until the count runs out
      coreReset_o <= sync0 | sync1 | (stretchCnt != 0);
    end
  end

endmodule
